//--- sources.f
snake_pkg.sv
snake_state_if.sv
arrow_decode.sv
apple_picker.sv
step_engine.sv
display_scan.sv
snake_top.sv
snake_checker.sv
snake_tb.sv

//--- snake_tb.sv
module snake_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int tb_step_cycles = 64;
	localparam int tb_scan_cycles = 1;
	// 400 steps of 64 clocks at 100 ns
	localparam int watchdog_ns = 400 * tb_step_cycles * 100;

	logic clk = 1'b0;
	logic reset;
	logic arrow_up;
	logic arrow_down;
	logic arrow_left;
	logic arrow_right;
	logic [7:0] led_segout;
	logic [2:0] led_scanout;
	logic [7:0] matrix_segout_r;
	logic [7:0] matrix_segout_g;
	logic [7:0] matrix_scanout;
	int cycle_cnt;

	// last captured frame by row
	logic [7:0] red_f [8];
	logic [7:0] green_f [8];
	logic [7:0] seg_f [8];
	logic [2:0] digit_sel_f [8];

	// expected head position and heading
	int head_row;
	int head_col;
	snake_pkg::dir_t head_dir;

	snake_top #(
		.step_cycles(tb_step_cycles),
		.scan_cycles(tb_scan_cycles)
	) dut (
		.clk(clk),
		.reset(reset),
		.arrow_up(arrow_up),
		.arrow_down(arrow_down),
		.arrow_left(arrow_left),
		.arrow_right(arrow_right),
		.led_segout(led_segout),
		.led_scanout(led_scanout),
		.matrix_segout_r(matrix_segout_r),
		.matrix_segout_g(matrix_segout_g),
		.matrix_scanout(matrix_scanout)
	);

	always #50 clk = ~clk;

	// steps land where the clock count since reset reads 63 mod 64
	always @(posedge clk or negedge reset) begin
		if (!reset) begin
			cycle_cnt <= 0;
		end else begin
			cycle_cnt <= cycle_cnt + 1;
		end
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAIL %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
			$display("Checks failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	function automatic int row_of(input logic [7:0] onehot);
		row_of = 0;
		for (int i = 0; i < 8; i++) begin
			if (onehot[i]) begin
				row_of = i;
			end
		end
	endfunction

	function automatic logic [7:0] col_mask(input int col);
		col_mask = 8'h80 >> col;
	endfunction

	function automatic bit opposite(input snake_pkg::dir_t a, input snake_pkg::dir_t b);
		case (a)
			snake_pkg::dir_up: opposite = b == snake_pkg::dir_down;
			snake_pkg::dir_down: opposite = b == snake_pkg::dir_up;
			snake_pkg::dir_left: opposite = b == snake_pkg::dir_right;
			default: opposite = b == snake_pkg::dir_left;
		endcase
	endfunction

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b0;
		arrow_up <= 1'b1;
		arrow_down <= 1'b1;
		arrow_left <= 1'b0;
		arrow_right <= 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b1;
		head_row = 0;
		head_col = 0;
		head_dir = snake_pkg::dir_down;
	endtask

	// holds one arrow pressed and leaves the rest idle
	task automatic press(input snake_pkg::dir_t d);
		@(posedge clk);
		arrow_up <= d != snake_pkg::dir_up;
		arrow_down <= d != snake_pkg::dir_down;
		arrow_left <= d == snake_pkg::dir_left;
		arrow_right <= d == snake_pkg::dir_right;
	endtask

	task automatic next_step();
		do begin
			@(posedge clk);
		end while (cycle_cnt % tb_step_cycles != tb_step_cycles - 1);
	endtask

	// one full scan of the matrix and the digits
	task automatic capture_frame();
		logic [7:0] seen;
		int r;
		seen = 8'd0;
		repeat (2) @(posedge clk);
		repeat (8) begin
			@(negedge clk);
			check($countones(matrix_scanout), 1, "one matrix row selected");
			r = row_of(matrix_scanout);
			seen[r] = 1'b1;
			red_f[r] = matrix_segout_r;
			green_f[r] = matrix_segout_g;
			seg_f[r] = led_segout;
			digit_sel_f[r] = led_scanout;
		end
		check(seen, 8'hff, "all eight rows scanned in one frame");
	endtask

	task automatic move_once(input snake_pkg::dir_t d);
		press(d);
		if (!opposite(d, head_dir)) begin
			head_dir = d;
		end
		case (head_dir)
			snake_pkg::dir_up: head_row = (head_row + 7) % 8;
			snake_pkg::dir_down: head_row = (head_row + 1) % 8;
			snake_pkg::dir_left: head_col = (head_col + 7) % 8;
			default: head_col = (head_col + 1) % 8;
		endcase
		next_step();
		capture_frame();
	endtask

	task automatic check_lone_head(input string what);
		for (int r = 0; r < 8; r++) begin
			check(green_f[r], (r == head_row) ? col_mask(head_col) : 8'd0, what);
		end
	endtask

	function automatic int count_green();
		count_green = 0;
		for (int r = 0; r < 8; r++) begin
			count_green += $countones(green_f[r]);
		end
	endfunction

	// the apple is the one red cell that is not body
	task automatic find_apple(output int ar, output int ac, output int n);
		logic [7:0] m;
		n = 0;
		ar = 0;
		ac = 0;
		for (int r = 0; r < 8; r++) begin
			m = red_f[r] & ~green_f[r];
			for (int c = 0; c < 8; c++) begin
				if (m & col_mask(c)) begin
					n++;
					ar = r;
					ac = c;
				end
			end
		end
	endtask

	task automatic test_reset_frame();
		apply_reset();
		capture_frame();
		for (int r = 0; r < 8; r++) begin
			check(green_f[r], (r == 0) ? 8'h80 : 8'h00,
				$sformatf("green row %0d after reset", r));
			check(red_f[r], (r == 0) ? 8'h80 : (r == 3) ? 8'h08 : 8'h00,
				$sformatf("red row %0d after reset", r));
			check(seg_f[r], (r == 2) ? snake_pkg::seg_patterns[0] : 8'h00,
				$sformatf("segments in row %0d after reset", r));
			check(digit_sel_f[r], (r < 3) ? r : 0, $sformatf("digit select in row %0d", r));
		end
	endtask

	task automatic test_wrap();
		apply_reset();
		repeat (10) begin
			move_once(snake_pkg::dir_down);
			check_lone_head("snake moving down");
		end
		// 10 mod 8 leaves the head in row 2, column 0
		check(green_f[2], 8'h80, "head cell after 10 steps down");
		for (int i = 0; i < 9; i++) begin
			move_once(snake_pkg::dir_right);
			check_lone_head("snake moving right");
			check(green_f[2], col_mask((i + 1) % 8), "column moving right");
		end
	endtask

	task automatic test_reversal();
		apply_reset();
		repeat (2) move_once(snake_pkg::dir_down);
		repeat (3) begin
			move_once(snake_pkg::dir_up);
			check_lone_head("up refused while moving down");
		end
		check(green_f[5], 8'h80, "head cell after refused reversal");
	endtask

	task automatic test_eating();
		int ar;
		int ac;
		int n;
		apply_reset();
		repeat (3) move_once(snake_pkg::dir_down);
		repeat (4) move_once(snake_pkg::dir_right);
		for (int r = 0; r < 8; r++) begin
			check(green_f[r], (r == 3) ? 8'h18 : 8'h00, "green after eating");
		end
		check(seg_f[0], 8'h00, "hundreds blank at score 1");
		check(seg_f[1], 8'h00, "tens blank at score 1");
		check(seg_f[2], snake_pkg::seg_patterns[1], "units at score 1");
		check(red_f[3] & 8'h08, 8'h08, "head lit red after eating");
		find_apple(ar, ac, n);
		check(n, 1, "one new apple off the body");
	endtask

	task automatic test_collision();
		int ar;
		int ac;
		int n;
		int len;
		logic [7:0] frozen_r [8];
		logic [7:0] frozen_g [8];
		apply_reset();
		capture_frame();
		len = 1;
		while (len < 5) begin
			find_apple(ar, ac, n);
			check(n, 1, "one apple on the board");
			// steering uses only down and right and never asks for a reversal
			while (head_row != ar || head_col != ac) begin
				if (head_row != ar) begin
					move_once(snake_pkg::dir_down);
				end else begin
					move_once(snake_pkg::dir_right);
				end
				check(green_f[head_row][7 - head_col], 1'b1, "head lit while steering");
			end
			len++;
			check(count_green(), len, "length after eating");
		end
		// a tight square runs into the body
		move_once(snake_pkg::dir_right);
		move_once(snake_pkg::dir_up);
		move_once(snake_pkg::dir_left);
		move_once(snake_pkg::dir_down);
		for (int r = 0; r < 8; r++) begin
			check(red_f[r], green_f[r], "red mirrors green after game over");
			frozen_r[r] = red_f[r];
			frozen_g[r] = green_f[r];
		end
		repeat (3) move_once(snake_pkg::dir_right);
		for (int r = 0; r < 8; r++) begin
			check(red_f[r], frozen_r[r], "red frozen after game over");
			check(green_f[r], frozen_g[r], "green frozen after game over");
		end
	endtask

	initial begin
		reset <= 1'b0;
		arrow_up <= 1'b1;
		arrow_down <= 1'b1;
		arrow_left <= 1'b0;
		arrow_right <= 1'b0;
		test_reset_frame();
		test_wrap();
		test_reversal();
		test_eating();
		test_collision();
		$display("All checks passed");
		$finish;
	end

	// the bound checker counts its failed assertions
	initial begin
		wait (dut.chk.error_count != 0);
		$display("an assertion in the bound checker failed");
		$display("Checks failed");
		$fatal(1, "checker assertion failed");
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- snake_checker.sv
module snake_checker (
	input logic clk,
	input logic reset,
	input logic [7:0] matrix_scanout,
	input logic [2:0] led_scanout,
	input logic over,
	input snake_pkg::cell_t head,
	input logic [7:0][7:0] body_map
);

	timeunit 1ns;
	timeprecision 1ps;

	// number of failed assertions so far
	int error_count = 0;

	// at most one matrix row driven at any time
	assert property (@(posedge clk) $onehot0(matrix_scanout))
		else begin
			$error("matrix_scanout drives more than one row");
			error_count++;
		end

	// once scanning runs a row stays selected
	assert property (@(posedge clk) disable iff (!reset)
		$onehot(matrix_scanout) |=> $onehot(matrix_scanout))
		else begin
			$error("matrix_scanout lost its row after the first scan");
			error_count++;
		end

	// only hundreds, tens and units exist
	assert property (@(posedge clk) led_scanout <= 3'd2)
		else begin
			$error("led_scanout selects a digit above 2");
			error_count++;
		end

	// game over holds until reset
	assert property (@(posedge clk) disable iff (!reset) over |=> over)
		else begin
			$error("game over dropped without reset");
			error_count++;
		end

	assert property (@(posedge clk) disable iff (!reset)
		body_map[head[5:3]][3'd7 - head[2:0]])
		else begin
			$error("head cell missing from body_map");
			error_count++;
		end

endmodule

bind snake_top snake_checker chk (
	.clk(clk),
	.reset(reset),
	.matrix_scanout(matrix_scanout),
	.led_scanout(led_scanout),
	.over(state.over),
	.head(state.head),
	.body_map(state.body_map)
);

//--- snake_top.sv
module snake_top #(
	parameter int step_cycles = snake_pkg::step_cycles_default,
	parameter int scan_cycles = snake_pkg::scan_cycles_default
) (
	input logic clk,
	input logic reset,
	input logic arrow_up,
	input logic arrow_down,
	input logic arrow_left,
	input logic arrow_right,
	output logic [7:0] led_segout,
	output logic [2:0] led_scanout,
	output logic [7:0] matrix_segout_r,
	output logic [7:0] matrix_segout_g,
	output logic [7:0] matrix_scanout
);

	snake_pkg::dir_t req_dir;

	snake_state_if state ();

	arrow_decode u_decode (
		.clk(clk),
		.reset(reset),
		.arrow_up(arrow_up),
		.arrow_down(arrow_down),
		.arrow_left(arrow_left),
		.arrow_right(arrow_right),
		.req_dir(req_dir)
	);

	step_engine #(
		.step_cycles(step_cycles)
	) u_engine (
		.clk(clk),
		.reset(reset),
		.req_dir(req_dir),
		.state(state.engine)
	);

	display_scan #(
		.scan_cycles(scan_cycles)
	) u_display (
		.clk(clk),
		.reset(reset),
		.state(state.display),
		.led_segout(led_segout),
		.led_scanout(led_scanout),
		.matrix_segout_r(matrix_segout_r),
		.matrix_segout_g(matrix_segout_g),
		.matrix_scanout(matrix_scanout)
	);

endmodule

//--- display_scan.sv
module display_scan #(
	parameter int scan_cycles = snake_pkg::scan_cycles_default
) (
	input logic clk,
	input logic reset,
	snake_state_if.display state,
	output logic [7:0] led_segout,
	output logic [2:0] led_scanout,
	output logic [7:0] matrix_segout_r,
	output logic [7:0] matrix_segout_g,
	output logic [7:0] matrix_scanout
);

	logic [$clog2(scan_cycles+1)-1:0] dwell;
	logic scan_edge;
	logic [2:0] row;
	logic load;
	logic [7:0] red_row;
	logic [3:0] digit;
	logic blank;
	logic [7:0] seg_code;

	assign scan_edge = int'(dwell) == scan_cycles - 1;

	always_comb begin
		// after game over the whole body lights red as well
		red_row = 8'd0;
		if (state.over) begin
			red_row = state.body_map[row];
		end else begin
			if (state.head[5:3] == row) begin
				red_row = red_row | (8'b1000_0000 >> state.head[2:0]);
			end
			if (state.apple[5:3] == row) begin
				red_row = red_row | (8'b1000_0000 >> state.apple[2:0]);
			end
		end

		// leading zeros stay dark, units always lit
		case (row)
			3'd0: begin
				digit = state.score[11:8];
				blank = state.score[11:8] == 4'd0;
			end
			3'd1: begin
				digit = state.score[7:4];
				blank = state.score[11:4] == 8'd0;
			end
			3'd2: begin
				digit = state.score[3:0];
				blank = 1'b0;
			end
			default: begin
				digit = 4'd0;
				blank = 1'b1;
			end
		endcase

		if (blank) begin
			seg_code = 8'd0;
		end else begin
			seg_code = snake_pkg::seg_patterns[digit];
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			dwell <= '0;
			row <= 3'd0;
			load <= 1'b0;
			led_segout <= 8'd0;
			led_scanout <= 3'd0;
			matrix_segout_r <= 8'd0;
			matrix_segout_g <= 8'd0;
			matrix_scanout <= 8'd0;
		end else begin
			if (scan_edge) begin
				dwell <= '0;
				row <= row + 3'd1;
			end else begin
				dwell <= dwell + 1'b1;
			end

			// outputs follow one cycle after the row moves
			load <= scan_edge;
			if (load) begin
				matrix_scanout <= 8'b0000_0001 << row;
				matrix_segout_g <= state.body_map[row];
				matrix_segout_r <= red_row;
				led_segout <= seg_code;
				if (row < 3'd3) begin
					led_scanout <= row;
				end else begin
					led_scanout <= 3'd0;
				end
			end
		end
	end

endmodule

//--- step_engine.sv
module step_engine #(
	parameter int step_cycles = snake_pkg::step_cycles_default
) (
	input logic clk,
	input logic reset,
	input snake_pkg::dir_t req_dir,
	snake_state_if.engine state
);

	logic [$clog2(step_cycles+1)-1:0] step_cnt;
	logic step_tick;
	snake_pkg::dir_t dir;
	snake_pkg::dir_t next_dir;
	snake_pkg::cell_t body [snake_pkg::max_length];
	logic [6:0] length;
	logic [6:0] tail_pos;
	snake_pkg::cell_t tail;
	snake_pkg::cell_t new_head;
	logic [snake_pkg::grid_size-1:0][snake_pkg::grid_size-1:0] clear_map;
	logic [snake_pkg::grid_size-1:0][snake_pkg::grid_size-1:0] next_map;
	logic hit;
	logic at_apple;
	logic advance;
	logic eat;
	snake_pkg::bcd_score_t score_inc;
	snake_pkg::cell_t next_apple;

	function automatic logic [7:0] row_bit(input logic [2:0] col);
		row_bit = 8'b1000_0000 >> col;
	endfunction

	apple_picker u_picker (
		.clk(clk),
		.reset(reset),
		.eat(eat),
		.occupied(next_map),
		.next_apple(next_apple)
	);

	assign step_tick = int'(step_cnt) == step_cycles - 1;

	always_comb begin
		// a reversal keeps the current heading
		if (req_dir[1] == dir[1] && req_dir[0] != dir[0]) begin
			next_dir = dir;
		end else begin
			next_dir = req_dir;
		end

		// 3-bit row and column wrap on their own
		new_head = state.head;
		case (next_dir)
			snake_pkg::dir_up: new_head[5:3] = state.head[5:3] - 3'd1;
			snake_pkg::dir_down: new_head[5:3] = state.head[5:3] + 3'd1;
			snake_pkg::dir_left: new_head[2:0] = state.head[2:0] - 3'd1;
			snake_pkg::dir_right: new_head[2:0] = state.head[2:0] + 3'd1;
		endcase

		// body[0] is the cell right behind the head
		tail_pos = length - 7'd2;
		if (length == 7'd1) begin
			tail = state.head;
		end else begin
			tail = body[tail_pos[5:0]];
		end

		clear_map = state.body_map;
		clear_map[tail[5:3]] = clear_map[tail[5:3]] & ~row_bit(tail[2:0]);
		hit = (clear_map[new_head[5:3]] & row_bit(new_head[2:0])) != 8'd0;
		at_apple = new_head == state.apple;

		// eating keeps the tail in place
		if (at_apple) begin
			next_map = state.body_map;
		end else begin
			next_map = clear_map;
		end
		next_map[new_head[5:3]] = next_map[new_head[5:3]] | row_bit(new_head[2:0]);

		score_inc = state.score;
		if (state.score[3:0] != 4'd9) begin
			score_inc[3:0] = state.score[3:0] + 4'd1;
		end else begin
			score_inc[3:0] = 4'd0;
			if (state.score[7:4] != 4'd9) begin
				score_inc[7:4] = state.score[7:4] + 4'd1;
			end else begin
				score_inc[7:4] = 4'd0;
				score_inc[11:8] = state.score[11:8] + 4'd1;
			end
		end
	end

	assign advance = step_tick && !state.over && !hit;
	assign eat = advance && at_apple;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			step_cnt <= '0;
			dir <= snake_pkg::start_dir;
			length <= 7'd1;
			state.head <= snake_pkg::start_cell;
			state.apple <= snake_pkg::start_apple;
			state.body_map <= '0;
			state.body_map[snake_pkg::start_cell[5:3]] <= row_bit(snake_pkg::start_cell[2:0]);
			state.score <= '0;
			state.over <= 1'b0;
		end else begin
			if (step_tick) begin
				step_cnt <= '0;
			end else begin
				step_cnt <= step_cnt + 1'b1;
			end

			if (step_tick && !state.over && hit) begin
				state.over <= 1'b1;
			end

			if (advance) begin
				dir <= next_dir;
				state.head <= new_head;
				state.body_map <= next_map;
				if (at_apple) begin
					length <= length + 7'd1;
					state.score <= score_inc;
					// the board is full once the last cell is taken
					if (length == 7'(snake_pkg::max_length - 1)) begin
						state.over <= 1'b1;
					end else begin
						state.apple <= next_apple;
					end
				end
			end
		end
	end

	// cell history, only the first length-1 entries matter
	always_ff @(posedge clk) begin
		if (advance) begin
			body[0] <= state.head;
			for (int i = 1; i < snake_pkg::max_length; i++) begin
				body[i] <= body[i-1];
			end
		end
	end

endmodule

//--- apple_picker.sv
module apple_picker (
	input logic clk,
	input logic reset,
	input logic eat,
	input logic [snake_pkg::grid_size-1:0][snake_pkg::grid_size-1:0] occupied,
	output snake_pkg::cell_t next_apple
);

	logic [7:0] rnd;
	logic [7:0] rnd_step;
	snake_pkg::cell_t cand;
	logic found;

	// xorshift 7/5/3 is a bijection that keeps a nonzero seed off zero
	always_comb begin
		rnd_step = rnd ^ (rnd << 7);
		rnd_step = rnd_step ^ (rnd_step >> 5);
		rnd_step = rnd_step ^ (rnd_step << 3);
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rnd <= snake_pkg::apple_seed;
		end else if (eat) begin
			rnd <= rnd_step;
		end
	end

	// odd stride visits all 64 cells and the first free one wins
	always_comb begin
		next_apple = rnd[5:0];
		found = 1'b0;
		cand = rnd[5:0];
		for (int i = 0; i < snake_pkg::max_length; i++) begin
			cand = snake_pkg::cell_t'(rnd[5:0] + snake_pkg::apple_stride * i);
			if (!found && !occupied[cand[5:3]][3'd7 - cand[2:0]]) begin
				found = 1'b1;
				next_apple = cand;
			end
		end
	end

endmodule

//--- arrow_decode.sv
module arrow_decode (
	input logic clk,
	input logic reset,
	input logic arrow_up,
	input logic arrow_down,
	input logic arrow_left,
	input logic arrow_right,
	output snake_pkg::dir_t req_dir
);

	// order is up, down, left, right
	// up and down idle high, left and right idle low
	logic [3:0] sync_1;
	logic [3:0] sync_2;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			sync_1 <= 4'b1100;
			sync_2 <= 4'b1100;
			req_dir <= snake_pkg::start_dir;
		end else begin
			sync_1 <= {arrow_up, arrow_down, arrow_left, arrow_right};
			sync_2 <= sync_1;
			// last pressed direction is held when nothing is pressed
			if (!sync_2[3]) begin
				req_dir <= snake_pkg::dir_up;
			end else if (!sync_2[2]) begin
				req_dir <= snake_pkg::dir_down;
			end else if (sync_2[1]) begin
				req_dir <= snake_pkg::dir_left;
			end else if (sync_2[0]) begin
				req_dir <= snake_pkg::dir_right;
			end
		end
	end

endmodule

//--- snake_state_if.sv
interface snake_state_if;

	snake_pkg::cell_t head;
	snake_pkg::cell_t apple;
	// one row per entry, column c at bit (7 - c)
	logic [snake_pkg::grid_size-1:0][snake_pkg::grid_size-1:0] body_map;
	snake_pkg::bcd_score_t score;
	logic over;

	modport engine (
		output head,
		output apple,
		output body_map,
		output score,
		output over
	);

	modport display (
		input head,
		input apple,
		input body_map,
		input score,
		input over
	);

endinterface

//--- snake_pkg.sv
package snake_pkg;

	// matrix geometry
	localparam int grid_size = 8;
	localparam int max_length = 64;

	// row in [5:3], column in [2:0]
	typedef logic [5:0] cell_t;

	// encoding follows the button decode order
	typedef enum logic [1:0] {
		dir_up = 2'd0,
		dir_down = 2'd1,
		dir_left = 2'd2,
		dir_right = 2'd3
	} dir_t;

	// hundreds, tens, units
	typedef logic [11:0] bcd_score_t;

	// state after reset
	localparam cell_t start_cell = 6'b000_000;
	localparam dir_t start_dir = dir_down;
	localparam cell_t start_apple = 6'b011_100;

	// apple generator
	localparam logic [7:0] apple_seed = 8'hEA;
	localparam int apple_stride = 39;

	// default timing for the board clock
	localparam int step_cycles_default = 5_000_000;
	localparam int scan_cycles_default = 8192;

	// segments a..g in bits 7..1, dot in bit 0
	localparam logic [7:0] seg_patterns [10] = '{
		8'b11111100,
		8'b01100000,
		8'b11011010,
		8'b11110010,
		8'b01100110,
		8'b10110110,
		8'b10111110,
		8'b11100000,
		8'b11111110,
		8'b11110110
	};

endpackage
